// ==== source/issuePkg.sv ====
package issuePkg;

	// Datapath width of the integer core
	localparam int xlen = 32;

	// Register file addressing
	localparam int regAddrW = 5;
	localparam int numRegs = 32;

	// Operand, immediate, writeback data and PC
	typedef logic [xlen-1:0] word_t;

	// Register number
	typedef logic [regAddrW-1:0] regAddr_t;

	// ALU function code passed from decode through to execute
	typedef logic [3:0] aluFn_t;

	// Memory operation code also passed through untouched
	typedef logic [3:0] memOp_t;

	// Operand B source select
	typedef logic [1:0] bSel_t;

	// Shift amount field of shift-immediate instructions
	typedef logic [4:0] shamt_t;

	// Operand B from rs2 read port
	localparam bSel_t bSelReg = 2'd0;
	// Operand B from sign-extended I-immediate
	localparam bSel_t bSelImm = 2'd1;
	// Operand B from zero-extended shamt
	localparam bSel_t bSelShamt = 2'd2;

	// Flush window counter
	typedef logic [1:0] flushCnt_t;

	// Bubbles after a taken branch or jump
	localparam flushCnt_t flushSlots = 2'd2;

	// Scoreboard FSM states
	typedef enum logic [1:0]
	{
		sbRun,
		sbFlush,
		sbHold
	} sbState_t;

endpackage

// ==== source/regFile.sv ====
module regFile (
	input logic clk,
	input logic nrst,
	// Commit-side write port
	input logic wrEn,
	input issuePkg::regAddr_t wrAddr,
	input issuePkg::word_t wrData,
	// Two combinational read ports
	input issuePkg::regAddr_t rdAddrA,
	input issuePkg::regAddr_t rdAddrB,
	output issuePkg::word_t rdDataA,
	output issuePkg::word_t rdDataB
);

	// Entry 0 is never written, so it stays at its reset value
	issuePkg::word_t regs [issuePkg::numRegs];

	logic bypassA;
	logic bypassB;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < issuePkg::numRegs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn && (wrAddr != '0))
		begin
			// x0 writes dropped here
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle writeback seen by the reader
	assign bypassA = wrEn && (wrAddr == rdAddrA);
	assign bypassB = wrEn && (wrAddr == rdAddrB);

	// x0 reads zero ahead of the bypass
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(bypassA ? wrData : regs[rdAddrA]);
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(bypassB ? wrData : regs[rdAddrB]);

endmodule

// ==== source/flushCounter.sv ====
module flushCounter (
	input logic clk,
	input logic nrst,
	// Taken branch seen this cycle
	input logic start,
	// One flush slot consumed
	input logic advance,
	// Window still open
	output logic busy
);

	issuePkg::flushCnt_t count;

	// Start wins over advance so a back-to-back branch reopens the window
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			count <= '0;
		end
		else if (start)
		begin
			count <= issuePkg::flushSlots;
		end
		else if (advance && (count != '0))
		begin
			count <= count - issuePkg::flushCnt_t'(1);
		end
		// advance low keeps the count through a memory hold
	end

	assign busy = (count != '0);

endmodule

// ==== source/hazardScoreboard.sv ====
module hazardScoreboard (
	input logic clk,
	input logic nrst,
	// Instruction in decode
	input logic decValid,
	input issuePkg::regAddr_t decRs1,
	input issuePkg::regAddr_t decRs2,
	input logic decUseRs1,
	input logic decUseRs2,
	input issuePkg::regAddr_t decRd,
	input logic decWe,
	// Writeback from commit
	input logic wbEn,
	input issuePkg::regAddr_t wbAddr,
	// Pipeline control
	input logic bjTaken,
	input logic memHold,
	input logic flushBusy,
	// Flush counter control
	output logic flushStart,
	output logic flushAdvance,
	// One-hot issue register commands
	output logic loadInstr,
	output logic loadBubble,
	output logic holdStage,
	// Back to decode
	output logic stall
);

	issuePkg::sbState_t state;
	issuePkg::sbState_t nextState;

	// One bit per register with a write still in flight
	logic [issuePkg::numRegs-1:0] pending;
	logic [issuePkg::numRegs-1:0] pendingSet;
	logic [issuePkg::numRegs-1:0] pendingClr;

	logic hitRs1;
	logic hitRs2;
	logic hazard;
	logic flushSlot;
	logic flushing;

	// A writeback this cycle resolves a RAW hit through the bypass
	assign hitRs1 = decUseRs1 && (decRs1 != '0) && pending[decRs1]
		&& !(wbEn && (wbAddr == decRs1));
	assign hitRs2 = decUseRs2 && (decRs2 != '0) && pending[decRs2]
		&& !(wbEn && (wbAddr == decRs2));
	assign hazard = decValid && (hitRs1 || hitRs2);

	// Window slot including the first cycle after a hold releases
	assign flushSlot = ((state == issuePkg::sbFlush) || (state == issuePkg::sbHold))
		&& flushBusy;
	assign flushing = bjTaken || flushSlot;

	// Priority hold, then flush, then hazard, then issue
	assign holdStage = memHold;
	assign loadBubble = !memHold && (flushing || hazard || !decValid);
	assign loadInstr = !memHold && !flushing && !hazard && decValid;
	// Wrong-path instructions are consumed, so no stall in the window
	assign stall = memHold || (!flushing && hazard);

	// Counter control
	assign flushStart = !memHold && bjTaken;
	assign flushAdvance = !memHold && !bjTaken && flushSlot;

	// Set on issue of a writer, clear on writeback
	always_comb
	begin
		pendingSet = '0;
		pendingClr = '0;
		if (loadInstr && decWe && (decRd != '0))
		begin
			pendingSet[decRd] = 1'b1;
		end
		if (wbEn)
		begin
			pendingClr[wbAddr] = 1'b1;
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pending <= '0;
		end
		else if (!memHold)
		begin
			// set applied last, so it wins a same-register clash
			pending <= (pending & ~pendingClr) | pendingSet;
		end
	end

	// Next state
	always_comb
	begin
		case (state)
			issuePkg::sbRun:
				nextState = bjTaken ? issuePkg::sbFlush : issuePkg::sbRun;
			issuePkg::sbFlush,
			issuePkg::sbHold:
				// Stay until the counter drains
				nextState = (bjTaken || flushBusy) ? issuePkg::sbFlush : issuePkg::sbRun;
			default:
				nextState = issuePkg::sbRun;
		endcase
		if (memHold)
		begin
			nextState = issuePkg::sbHold;
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= issuePkg::sbRun;
		end
		else
		begin
			state <= nextState;
		end
	end

endmodule

// ==== source/issueRegister.sv ====
module issueRegister (
	input logic clk,
	input logic nrst,
	// Commands from the scoreboard
	input logic loadInstr,
	input logic loadBubble,
	input logic holdStage,
	// Decoded fields
	input issuePkg::regAddr_t decRd,
	input logic decWe,
	input issuePkg::aluFn_t decAluFn,
	input issuePkg::memOp_t decMemOp,
	input issuePkg::bSel_t decBSel,
	input issuePkg::word_t decImm,
	input issuePkg::shamt_t decShamt,
	input issuePkg::word_t decPc,
	// Register file read data
	input issuePkg::word_t rsDataA,
	input issuePkg::word_t rsDataB,
	// Toward execute
	output logic exValid,
	output issuePkg::regAddr_t exRd,
	output logic exWe,
	output issuePkg::aluFn_t exAluFn,
	output issuePkg::memOp_t exMemOp,
	output issuePkg::word_t exPc,
	output issuePkg::word_t exImm,
	output issuePkg::word_t exOpA,
	output issuePkg::word_t exOpB
);

	// Operand B before the register
	issuePkg::word_t opBNext;

	always_comb
	begin
		case (decBSel)
			issuePkg::bSelReg:
				opBNext = rsDataB;
			issuePkg::bSelImm:
				opBNext = decImm;
			issuePkg::bSelShamt:
				// Shift amount zero extended
				opBNext = issuePkg::word_t'(decShamt);
			default:
				opBNext = rsDataB;
		endcase
	end

	// Control fields
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			exValid <= 1'b0;
			exWe <= 1'b0;
			exRd <= '0;
			exAluFn <= '0;
			exMemOp <= '0;
		end
		else if (holdStage)
		begin
			// Frozen under memory hold
			exValid <= exValid;
			exWe <= exWe;
			exRd <= exRd;
			exAluFn <= exAluFn;
			exMemOp <= exMemOp;
		end
		else if (loadBubble)
		begin
			// Bubble carries no side effects into execute
			exValid <= 1'b0;
			exWe <= 1'b0;
			exRd <= '0;
			exAluFn <= '0;
			exMemOp <= '0;
		end
		else if (loadInstr)
		begin
			exValid <= 1'b1;
			exWe <= decWe;
			exRd <= decRd;
			exAluFn <= decAluFn;
			exMemOp <= decMemOp;
		end
	end

	// Payload fields
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			exPc <= '0;
			exImm <= '0;
			exOpA <= '0;
			exOpB <= '0;
		end
		else if (loadInstr && !holdStage)
		begin
			exPc <= decPc;
			exImm <= decImm;
			exOpA <= rsDataA;
			exOpB <= opBNext;
		end
		// Bubbles leave the payload as it was
	end

endmodule

// ==== source/issueStage.sv ====
module issueStage (
	input logic clk,
	input logic nrst,
	// Decode side
	input logic decValid,
	input issuePkg::regAddr_t decRs1,
	input issuePkg::regAddr_t decRs2,
	input logic decUseRs1,
	input logic decUseRs2,
	input issuePkg::regAddr_t decRd,
	input logic decWe,
	input issuePkg::aluFn_t decAluFn,
	input issuePkg::memOp_t decMemOp,
	input issuePkg::bSel_t decBSel,
	input issuePkg::word_t decImm,
	input issuePkg::shamt_t decShamt,
	input issuePkg::word_t decPc,
	output logic stall,
	// Commit writeback
	input logic wbEn,
	input issuePkg::regAddr_t wbAddr,
	input issuePkg::word_t wbData,
	// Branch result and memory hold
	input logic bjTaken,
	input logic memHold,
	// Execute side
	output logic exValid,
	output issuePkg::regAddr_t exRd,
	output logic exWe,
	output issuePkg::aluFn_t exAluFn,
	output issuePkg::memOp_t exMemOp,
	output issuePkg::word_t exPc,
	output issuePkg::word_t exImm,
	output issuePkg::word_t exOpA,
	output issuePkg::word_t exOpB
);

	// Source operands straight from the read ports
	issuePkg::word_t rsDataA;
	issuePkg::word_t rsDataB;

	// Flush window handshake
	logic flushStart;
	logic flushAdvance;
	logic flushBusy;

	// Issue register commands
	logic loadInstr;
	logic loadBubble;
	logic holdStage;

	regFile uRegFile (
		.clk(clk), .nrst(nrst),
		.wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData),
		.rdAddrA(decRs1), .rdAddrB(decRs2),
		.rdDataA(rsDataA), .rdDataB(rsDataB)
	);

	hazardScoreboard uScoreboard (
		.clk(clk), .nrst(nrst),
		.decValid(decValid), .decRs1(decRs1), .decRs2(decRs2),
		.decUseRs1(decUseRs1), .decUseRs2(decUseRs2),
		.decRd(decRd), .decWe(decWe),
		.wbEn(wbEn), .wbAddr(wbAddr),
		.bjTaken(bjTaken), .memHold(memHold), .flushBusy(flushBusy),
		.flushStart(flushStart), .flushAdvance(flushAdvance),
		.loadInstr(loadInstr), .loadBubble(loadBubble), .holdStage(holdStage),
		.stall(stall)
	);

	flushCounter uFlushCounter (
		.clk(clk), .nrst(nrst),
		.start(flushStart), .advance(flushAdvance), .busy(flushBusy)
	);

	issueRegister uIssueReg (
		.clk(clk), .nrst(nrst),
		.loadInstr(loadInstr), .loadBubble(loadBubble), .holdStage(holdStage),
		.decRd(decRd), .decWe(decWe), .decAluFn(decAluFn), .decMemOp(decMemOp),
		.decBSel(decBSel), .decImm(decImm), .decShamt(decShamt), .decPc(decPc),
		.rsDataA(rsDataA), .rsDataB(rsDataB),
		.exValid(exValid), .exRd(exRd), .exWe(exWe),
		.exAluFn(exAluFn), .exMemOp(exMemOp), .exPc(exPc),
		.exImm(exImm), .exOpA(exOpA), .exOpB(exOpB)
	);

endmodule

// ==== tests/issueVectors.svh ====
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

// First row line holds valid rs1 rs2 useRs1 useRs2 rd we aluFn memOp bSel imm shamt pc
// Second row line holds wbEn wbAddr wbData bjTaken memHold and then the expected
// stall exValid exRd exWe exAluFn exMemOp exPc exImm exOpA exOpB
// bSel codes 0 reg, 1 imm, 2 shamt
// Stall is sampled before the edge, ex fields after it

typedef struct packed {
	// Decode side
	int valid, rs1, rs2, use1, use2, rd, we;
	int fn, mop, bSel, imm, shamt, pc;
	// Writeback and control
	int wbEn, wbAddr, wbData, bj, hold;
	// Expected response
	int stall, exValid, exRd, exWe, exFn, exMop;
	int exPc, exImm, exOpA, exOpB;
} vector_t;

function automatic void loadVectors();
	// Reset values, then x0 write and read
	addVector("idle", vector_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
	addVector("x0 write", vector_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		1, 0, 'hDEAD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
	addVector("x0 read", vector_t'{1, 0, 0, 1, 1, 1, 0, 3, 0, 0, 'h5, 0, 'h100,
		0, 0, 0, 0, 0, 0, 1, 1, 0, 3, 0, 'h100, 'h5, 0, 0});
	// Preload x1 and x2 while bubbles keep the payload
	addVector("load x1", vector_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		1, 1, 'h11111111, 0, 0, 0, 0, 0, 0, 0, 0, 'h100, 'h5, 0, 0});
	addVector("load x2", vector_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		1, 2, 'h22222222, 0, 0, 0, 0, 0, 0, 0, 0, 'h100, 'h5, 0, 0});
	// Operand B sources
	addVector("opB reg", vector_t'{1, 1, 2, 1, 1, 3, 1, 1, 0, 0, 'h7, 9, 'h104,
		0, 0, 0, 0, 0, 0, 1, 3, 1, 1, 0, 'h104, 'h7, 'h11111111, 'h22222222});
	addVector("opB imm", vector_t'{1, 2, 1, 1, 0, 4, 1, 2, 0, 1, 'hFFFFFFF0, 9, 'h108,
		0, 0, 0, 0, 0, 0, 1, 4, 1, 2, 0, 'h108, 'hFFFFFFF0, 'h22222222, 'hFFFFFFF0});
	addVector("opB shamt", vector_t'{1, 1, 31, 1, 0, 0, 0, 5, 0, 2, 'h1F, 13, 'h10C,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 5, 0, 'h10C, 'h1F, 'h11111111, 'hD});
	// x5 writer, then a reader stalled until the writeback
	addVector("raw writer", vector_t'{1, 1, 0, 1, 0, 5, 1, 1, 0, 1, 'h40, 0, 'h110,
		0, 0, 0, 0, 0, 0, 1, 5, 1, 1, 0, 'h110, 'h40, 'h11111111, 'h40});
	addVector("raw stall1", vector_t'{1, 5, 2, 1, 1, 6, 1, 4, 2, 0, 0, 0, 'h114,
		0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 'h110, 'h40, 'h11111111, 'h40});
	addVector("raw stall2", vector_t'{1, 5, 2, 1, 1, 6, 1, 4, 2, 0, 0, 0, 'h114,
		0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 'h110, 'h40, 'h11111111, 'h40});
	// Writeback data reaches opA through the bypass
	addVector("raw bypass", vector_t'{1, 5, 2, 1, 1, 6, 1, 4, 2, 0, 0, 0, 'h114,
		1, 5, 'h55AA55AA, 0, 0, 0, 1, 6, 1, 4, 2, 'h114, 0, 'h55AA55AA, 'h22222222});
	// Taken branch with wrong-path writers of x7 x8 x9
	addVector("bj pulse", vector_t'{1, 1, 0, 1, 0, 7, 1, 1, 0, 1, 'h1, 0, 'h118,
		0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 'h114, 0, 'h55AA55AA, 'h22222222});
	// Reads pending x4 but the flush hides the hazard
	addVector("flush 1", vector_t'{1, 4, 0, 1, 0, 8, 1, 1, 0, 0, 0, 0, 'h11C,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h114, 0, 'h55AA55AA, 'h22222222});
	addVector("flush 2", vector_t'{1, 1, 0, 1, 0, 9, 1, 1, 0, 0, 0, 0, 'h120,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h114, 0, 'h55AA55AA, 'h22222222});
	addVector("post flush", vector_t'{1, 7, 9, 1, 1, 10, 1, 6, 0, 0, 'h3, 0, 'h124,
		0, 0, 0, 0, 0, 0, 1, 10, 1, 6, 0, 'h124, 'h3, 0, 0});
	// Second branch with a memory hold inside the window
	addVector("bj again", vector_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 'h124, 'h3, 0, 0});
	addVector("flush 1b", vector_t'{1, 1, 0, 1, 0, 11, 1, 1, 0, 0, 0, 0, 'h12C,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h124, 'h3, 0, 0});
	addVector("hold 1", vector_t'{1, 1, 0, 1, 0, 12, 1, 2, 0, 0, 0, 0, 'h130,
		0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 'h124, 'h3, 0, 0});
	addVector("hold 2", vector_t'{1, 1, 0, 1, 0, 12, 1, 2, 0, 0, 0, 0, 'h130,
		0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 'h124, 'h3, 0, 0});
	addVector("hold 3", vector_t'{1, 1, 0, 1, 0, 12, 1, 2, 0, 0, 0, 0, 'h130,
		0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 'h124, 'h3, 0, 0});
	// Remaining slot 2 after the hold lifts
	addVector("release", vector_t'{1, 1, 0, 1, 0, 12, 1, 2, 0, 0, 0, 0, 'h130,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h124, 'h3, 0, 0});
	addVector("resume", vector_t'{1, 12, 1, 1, 1, 13, 0, 7, 1, 0, 'h8, 0, 'h134,
		0, 0, 0, 0, 0, 0, 1, 13, 0, 7, 1, 'h134, 'h8, 0, 'h11111111});
	// Hold over a valid instruction in execute
	addVector("hold valid", vector_t'{1, 1, 0, 1, 0, 14, 1, 3, 0, 0, 0, 0, 'h138,
		0, 0, 0, 0, 1, 1, 1, 13, 0, 7, 1, 'h134, 'h8, 0, 'h11111111});
	// Pending x6 read through rs2 only
	addVector("raw rs2", vector_t'{1, 0, 6, 0, 1, 0, 0, 0, 0, 0, 0, 0, 'h13C,
		0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 'h134, 'h8, 0, 'h11111111});
	addVector("idle end", vector_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h134, 'h8, 0, 'h11111111});
endfunction

`endif

// ==== tests/issueStageTb.sv ====
module issueStageTb;

	timeunit 1ns;
	timeprecision 100ps;

	// Clock period in ns, reset length in cycles
	localparam int clkPeriod = 8;
	localparam int resetCycles = 5;

	`include "issueVectors.svh"

	logic clk;
	logic nrst;

	// Decode side
	logic decValid;
	issuePkg::regAddr_t decRs1;
	issuePkg::regAddr_t decRs2;
	logic decUseRs1;
	logic decUseRs2;
	issuePkg::regAddr_t decRd;
	logic decWe;
	issuePkg::aluFn_t decAluFn;
	issuePkg::memOp_t decMemOp;
	issuePkg::bSel_t decBSel;
	issuePkg::word_t decImm;
	issuePkg::shamt_t decShamt;
	issuePkg::word_t decPc;
	logic stall;

	// Writeback and control
	logic wbEn;
	issuePkg::regAddr_t wbAddr;
	issuePkg::word_t wbData;
	logic bjTaken;
	logic memHold;

	// Execute side
	logic exValid;
	issuePkg::regAddr_t exRd;
	logic exWe;
	issuePkg::aluFn_t exAluFn;
	issuePkg::memOp_t exMemOp;
	issuePkg::word_t exPc;
	issuePkg::word_t exImm;
	issuePkg::word_t exOpA;
	issuePkg::word_t exOpB;

	// Vector table and run bookkeeping
	vector_t vectors[$];
	string names[$];
	logic tableReady;

	issueStage i_dut (
		.clk(clk), .nrst(nrst),
		.decValid(decValid), .decRs1(decRs1), .decRs2(decRs2),
		.decUseRs1(decUseRs1), .decUseRs2(decUseRs2), .decRd(decRd), .decWe(decWe),
		.decAluFn(decAluFn), .decMemOp(decMemOp), .decBSel(decBSel),
		.decImm(decImm), .decShamt(decShamt), .decPc(decPc), .stall(stall),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.bjTaken(bjTaken), .memHold(memHold),
		.exValid(exValid), .exRd(exRd), .exWe(exWe), .exAluFn(exAluFn),
		.exMemOp(exMemOp), .exPc(exPc), .exImm(exImm), .exOpA(exOpA), .exOpB(exOpB)
	);

	function automatic void addVector(input string name, input vector_t v);
		names.push_back(name);
		vectors.push_back(v);
	endfunction

	// Table columns onto the DUT ports
	task automatic applyInputs(input vector_t v);
		decValid = v.valid[0];
		decRs1 = issuePkg::regAddr_t'(v.rs1);
		decRs2 = issuePkg::regAddr_t'(v.rs2);
		decUseRs1 = v.use1[0];
		decUseRs2 = v.use2[0];
		decRd = issuePkg::regAddr_t'(v.rd);
		decWe = v.we[0];
		decAluFn = issuePkg::aluFn_t'(v.fn);
		decMemOp = issuePkg::memOp_t'(v.mop);
		decBSel = issuePkg::bSel_t'(v.bSel);
		decImm = issuePkg::word_t'(v.imm);
		decShamt = issuePkg::shamt_t'(v.shamt);
		decPc = issuePkg::word_t'(v.pc);
		wbEn = v.wbEn[0];
		wbAddr = issuePkg::regAddr_t'(v.wbAddr);
		wbData = issuePkg::word_t'(v.wbData);
		bjTaken = v.bj[0];
		memHold = v.hold[0];
	endtask

	task automatic checkField(input string testName, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[ERROR] %s: %s expected 'h%0h, actual 'h%0h",
				testName, field, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch on %s in vector %s", field, testName);
		end
	endtask

	// Registered execute outputs after the edge
	task automatic checkOutputs(input string testName, input vector_t v);
		checkField(testName, "exValid", v.exValid, 32'(exValid));
		checkField(testName, "exRd", v.exRd, 32'(exRd));
		checkField(testName, "exWe", v.exWe, 32'(exWe));
		checkField(testName, "exAluFn", v.exFn, 32'(exAluFn));
		checkField(testName, "exMemOp", v.exMop, 32'(exMemOp));
		checkField(testName, "exPc", v.exPc, exPc);
		checkField(testName, "exImm", v.exImm, exImm);
		checkField(testName, "exOpA", v.exOpA, exOpA);
		checkField(testName, "exOpB", v.exOpB, exOpB);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Four periods per row plus reset
	initial
	begin
		wait (tableReady);
		#((vectors.size() * 4 + resetCycles) * clkPeriod);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired before the vector table finished");
	end

	initial
	begin
		tableReady = 1'b0;
		nrst = 1'b0;
		applyInputs('0);
		loadVectors();
		tableReady = 1'b1;
		repeat (resetCycles) @(negedge clk);
		nrst = 1'b1;
		for (int i = 0; i < vectors.size(); i++)
		begin
			// Inputs change on the falling edge
			applyInputs(vectors[i]);
			// stall is combinational, sampled mid low phase
			#(clkPeriod / 4);
			checkField(names[i], "stall", vectors[i].stall, 32'(stall));
			@(negedge clk);
			checkOutputs(names[i], vectors[i]);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== issueStage.f ====
+incdir+tests
source/issuePkg.sv
source/regFile.sv
source/flushCounter.sv
source/hazardScoreboard.sv
source/issueRegister.sv
source/issueStage.sv
tests/issueStageTb.sv

// ==== build.sh ====
#!/bin/sh
# Compile the issue stage testbench with Verilator and run it.
# Exit status is nonzero when the build fails or the simulation ends in $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f issueStage.f --top-module issueStageTb -o issueStageSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/issueStageSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
